//--- list.f
+incdir+hw
hw/bus_pkg.sv
hw/arb_pkg.sv
hw/frame_serializer.sv
hw/master_port.sv
hw/slave_port.sv
hw/bus_arbiter.sv
hw/bus_top.sv
dv/bus_properties.sv
dv/bus_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module bus_tb -f list.f -o bus_sim \
	&& ./obj_dir/bus_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- dv/bus_tb.sv
// testbench for the serial bus core with directed and random commands checked against a ram model
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_tb;

	import bus_pkg::*;

	localparam int N_RANDOM    = 90;
	// 40 cycles for each of at most 200 commands plus slack
	localparam int CYCLE_LIMIT = 200 * 40 + 400;
	localparam int DONE_WAIT   = 100;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       m1_cmd_strobe, m1_cmd_write, m1_busy, m1_done, m1_err;
	logic       m2_cmd_strobe, m2_cmd_write, m2_busy, m2_done, m2_err;
	slave_sel_t m1_cmd_slave, m2_cmd_slave;
	addr_t      m1_cmd_addr, m2_cmd_addr;
	data_t      m1_cmd_wdata, m2_cmd_wdata, m1_rdata, m2_rdata;

	// reference ram images for each mapped slave
	data_t ram_model [`NUM_SLAVES][2 ** `ADDR_LEN];
	bit    written [`NUM_SLAVES][2 ** `ADDR_LEN];
	// addresses that reads may pick from
	addr_t wr_list0 [$];
	addr_t wr_list1 [$];
	int    seed = 13846;
	int    cycle = 0;
	logic  m1_done_q, m2_done_q;

	bus_top i_bus_top (.*);

	// 100 ns period
	always #50 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with commands still pending", cycle);
			$display("SOME TESTS FAILED");
			$fatal(1, "watchdog expired");
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	// grant overlap and done width seen mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			assert (!(i_bus_top.m1_grant && i_bus_top.m2_grant))
				else stop_run("both masters were granted in the same cycle");
			assert (!(m1_done && m1_done_q) && !(m2_done && m2_done_q))
				else stop_run("a done strobe lasted more than one cycle");
		end
		m1_done_q <= m1_done;
		m2_done_q <= m2_done;
	end

	task automatic drive_cmd(input int m, input logic stb, input logic wr, input slave_sel_t sel,
		input addr_t addr, input data_t wdata);
		if (m == 0) begin
			m1_cmd_strobe = stb;
			m1_cmd_write  = wr;
			m1_cmd_slave  = sel;
			m1_cmd_addr   = addr;
			m1_cmd_wdata  = wdata;
		end else begin
			m2_cmd_strobe = stb;
			m2_cmd_write  = wr;
			m2_cmd_slave  = sel;
			m2_cmd_addr   = addr;
			m2_cmd_wdata  = wdata;
		end
	endtask

	function automatic logic port_busy(input int m);
		return (m == 0) ? m1_busy : m2_busy;
	endfunction

	function automatic logic port_done(input int m);
		return (m == 0) ? m1_done : m2_done;
	endfunction

	// one command on master m checked for busy, latency, err and read data
	task automatic run_cmd(input int m, input logic wr, input slave_sel_t sel, input addr_t addr,
		input data_t wdata, input string name);
		logic  other_idle;
		logic  solo;
		logic  mapped;
		logic  got_err;
		data_t got_rdata;
		data_t exp_rdata;
		int    lat;
		int    exp_lat;
		while (port_busy(m)) begin
			@(negedge clk);
		end
		other_idle = !port_busy(1 - m);
		mapped     = (sel < slave_sel_t'(`NUM_SLAVES));
		drive_cmd(m, 1'b1, wr, sel, addr, wdata);
		@(negedge clk);
		drive_cmd(m, 1'b0, 1'b0, '0, '0, '0);
		// other side busy now means it strobed with us
		solo = other_idle && !port_busy(1 - m);
		lat  = 1;
		while (!port_done(m)) begin
			// busy covers every cycle from the strobe up to done
			assert (port_busy(m))
				else stop_run($sformatf("ERROR %s: busy expected 1 actual %0b",
					name, port_busy(m)));
			@(negedge clk);
			lat++;
			if (lat > DONE_WAIT) begin
				stop_run($sformatf("%s: master %0d never reported done", name, m + 1));
			end
		end
		got_err   = (m == 0) ? m1_err : m2_err;
		got_rdata = (m == 0) ? m1_rdata : m2_rdata;
		// req, grant, 21 frame bits, slave step, report; reads add 7 return bits
		exp_lat   = (wr || !mapped) ? 25 : 32;
		if (solo) begin
			assert (lat == exp_lat)
				else stop_run($sformatf("ERROR %s: latency expected %0d actual %0d",
					name, exp_lat, lat));
		end
		assert (got_err == !mapped)
			else stop_run($sformatf("ERROR %s: err expected %0b actual %0b",
				name, !mapped, got_err));
		if (mapped && wr) begin
			ram_model[sel[0]][addr] = wdata;
			if (!written[sel[0]][addr]) begin
				written[sel[0]][addr] = 1'b1;
				if (sel[0]) begin
					wr_list1.push_back(addr);
				end else begin
					wr_list0.push_back(addr);
				end
			end
		end else if (mapped) begin
			exp_rdata = ram_model[sel[0]][addr];
			assert (got_rdata == exp_rdata)
				else stop_run($sformatf("ERROR %s: rdata expected %02h actual %02h",
					name, exp_rdata, got_rdata));
		end
	endtask

	// random traffic for one master
	task automatic random_loop(input int m);
		int         kind;
		logic       wr;
		slave_sel_t sel;
		addr_t      addr;
		for (int n = 0; n < N_RANDOM; n++) begin
			repeat ($random(seed) & 3) begin
				@(negedge clk);
			end
			kind = $random(seed) & 7;
			wr   = (kind < 4);
			sel  = slave_sel_t'($random(seed) & 1);
			// narrow range on odd kinds so writes collide
			addr = addr_t'($random(seed) & (kind[0] ? 63 : 4095));
			if (kind == 0) begin
				sel = slave_sel_t'(2 + ($random(seed) & 1));
			end else if (!wr) begin
				if (sel[0] && wr_list1.size() > 0) begin
					addr = wr_list1[$unsigned($random(seed)) % wr_list1.size()];
				end else if (!sel[0] && wr_list0.size() > 0) begin
					addr = wr_list0[$unsigned($random(seed)) % wr_list0.size()];
				end else begin
					wr = 1'b1;
				end
			end
			run_cmd(m, wr, sel, addr, data_t'($random(seed)),
				$sformatf("random_m%0d_%0d", m + 1, n));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		drive_cmd(0, 1'b0, 1'b0, '0, '0, '0);
		drive_cmd(1, 1'b0, 1'b0, '0, '0, '0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (!m1_busy && !m1_done && !m1_err && !m2_busy && !m2_done && !m2_err)
			else stop_run("busy, done or err not low after reset");
		// write then read back
		run_cmd(0, 1'b1, 2'd0, 12'h123, 8'h5a, "write_read_wr");
		run_cmd(0, 1'b0, 2'd0, 12'h123, 8'h00, "write_read_rd");
		// same address in the other slave
		run_cmd(1, 1'b1, 2'd1, 12'h123, 8'ha5, "slave_indep_wr_s1");
		run_cmd(1, 1'b0, 2'd0, 12'h123, 8'h00, "slave_indep_rd_s0");
		run_cmd(1, 1'b0, 2'd1, 12'h123, 8'h00, "slave_indep_rd_s1");
		// unmapped selects must leave both rams as they were
		run_cmd(0, 1'b1, 2'd2, 12'h123, 8'hff, "unmapped_wr");
		run_cmd(1, 1'b0, 2'd3, 12'h123, 8'h00, "unmapped_rd");
		run_cmd(0, 1'b0, 2'd0, 12'h123, 8'h00, "unmapped_chk_s0");
		run_cmd(0, 1'b0, 2'd1, 12'h123, 8'h00, "unmapped_chk_s1");
		// both masters strobe in the same cycle
		fork
			run_cmd(0, 1'b1, 2'd0, 12'h200, 8'h11, "contend_wr_m1");
			run_cmd(1, 1'b1, 2'd1, 12'h200, 8'h22, "contend_wr_m2");
		join
		fork
			run_cmd(0, 1'b0, 2'd1, 12'h200, 8'h00, "contend_rd_m1");
			run_cmd(1, 1'b0, 2'd0, 12'h200, 8'h00, "contend_rd_m2");
		join
		fork
			random_loop(0);
			random_loop(1);
		join
		@(negedge clk);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- dv/bus_properties.sv
// bus protocol assertions on arbiter grants, slave valids and done strobes
`timescale 1ns/1ps

module bus_properties (
	input logic                clk,
	input logic                rst_n,
	input arb_pkg::arb_state_t state,
	input logic                m1_grant,
	input logic                m2_grant,
	input logic                s1_rx_valid,
	input logic                s2_rx_valid,
	input logic                m1_bus_done,
	input logic                m2_bus_done
);

	import arb_pkg::*;

	// single owner
	grant_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(m1_grant && m2_grant))
		else $error("m1_grant and m2_grant high together");

	// frame bits reach a slave only during a granted transfer
	rx_valid_owned: assert property (@(posedge clk) disable iff (!rst_n)
		(s1_rx_valid || s2_rx_valid) |-> ((m1_grant || m2_grant) && state == ARB_XFER))
		else $error("slave rx_valid high without a granted transfer");

	// done back to the owner is a one cycle pulse
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(m1_bus_done || m2_bus_done) |=> !(m1_bus_done || m2_bus_done))
		else $error("bus done held longer than one cycle");

endmodule

bind bus_arbiter bus_properties i_bus_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.state      (state),
	.m1_grant   (m1_grant),
	.m2_grant   (m2_grant),
	.s1_rx_valid(s1_rx_valid),
	.s2_rx_valid(s2_rx_valid),
	.m1_bus_done(m1_bus_done),
	.m2_bus_done(m2_bus_done)
);

//--- hw/bus_top.sv
// serial bus core, two masters and two block ram slaves around one arbiter
`timescale 1ns/1ps

module bus_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                m1_cmd_strobe,
	input  logic                m1_cmd_write,
	input  bus_pkg::slave_sel_t m1_cmd_slave,
	input  bus_pkg::addr_t      m1_cmd_addr,
	input  bus_pkg::data_t      m1_cmd_wdata,
	output logic                m1_busy,
	output logic                m1_done,
	output logic                m1_err,
	output bus_pkg::data_t      m1_rdata,
	input  logic                m2_cmd_strobe,
	input  logic                m2_cmd_write,
	input  bus_pkg::slave_sel_t m2_cmd_slave,
	input  bus_pkg::addr_t      m2_cmd_addr,
	input  bus_pkg::data_t      m2_cmd_wdata,
	output logic                m2_busy,
	output logic                m2_done,
	output logic                m2_err,
	output bus_pkg::data_t      m2_rdata
);

	import bus_pkg::*;

	// master to arbiter
	logic       m1_req, m1_grant, m1_tx_valid, m1_tx_bit, m1_bus_done;
	logic       m2_req, m2_grant, m2_tx_valid, m2_tx_bit, m2_bus_done;
	slave_sel_t m1_slave_sel, m2_slave_sel;
	// shared return lines to the masters
	logic       m_rx_valid, m_rx_bit, bus_err;
	// arbiter to slaves
	logic       s1_rx_valid, s2_rx_valid, s_rx_bit;
	logic       s1_tx_valid, s1_tx_bit, s1_done;
	logic       s2_tx_valid, s2_tx_bit, s2_done;

	master_port i_master1 (
		.clk(clk), .rst_n(rst_n),
		.cmd_strobe(m1_cmd_strobe), .cmd_write(m1_cmd_write), .cmd_slave(m1_cmd_slave),
		.cmd_addr(m1_cmd_addr), .cmd_wdata(m1_cmd_wdata),
		.busy(m1_busy), .done(m1_done), .err(m1_err), .rdata(m1_rdata),
		.req(m1_req), .slave_sel(m1_slave_sel), .grant(m1_grant),
		.tx_valid(m1_tx_valid), .tx_bit(m1_tx_bit),
		.rx_valid(m_rx_valid), .rx_bit(m_rx_bit), .bus_done(m1_bus_done), .bus_err(bus_err)
	);

	master_port i_master2 (
		.clk(clk), .rst_n(rst_n),
		.cmd_strobe(m2_cmd_strobe), .cmd_write(m2_cmd_write), .cmd_slave(m2_cmd_slave),
		.cmd_addr(m2_cmd_addr), .cmd_wdata(m2_cmd_wdata),
		.busy(m2_busy), .done(m2_done), .err(m2_err), .rdata(m2_rdata),
		.req(m2_req), .slave_sel(m2_slave_sel), .grant(m2_grant),
		.tx_valid(m2_tx_valid), .tx_bit(m2_tx_bit),
		.rx_valid(m_rx_valid), .rx_bit(m_rx_bit), .bus_done(m2_bus_done), .bus_err(bus_err)
	);

	slave_port i_slave1 (
		.clk(clk), .rst_n(rst_n), .rx_valid(s1_rx_valid), .rx_bit(s_rx_bit),
		.tx_valid(s1_tx_valid), .tx_bit(s1_tx_bit), .done(s1_done)
	);

	slave_port i_slave2 (
		.clk(clk), .rst_n(rst_n), .rx_valid(s2_rx_valid), .rx_bit(s_rx_bit),
		.tx_valid(s2_tx_valid), .tx_bit(s2_tx_bit), .done(s2_done)
	);

	bus_arbiter i_arbiter (
		.clk(clk), .rst_n(rst_n),
		.m1_req(m1_req), .m2_req(m2_req),
		.m1_slave_sel(m1_slave_sel), .m2_slave_sel(m2_slave_sel),
		.m1_grant(m1_grant), .m2_grant(m2_grant),
		.m1_tx_valid(m1_tx_valid), .m1_tx_bit(m1_tx_bit),
		.m2_tx_valid(m2_tx_valid), .m2_tx_bit(m2_tx_bit),
		.s1_rx_valid(s1_rx_valid), .s2_rx_valid(s2_rx_valid), .s_rx_bit(s_rx_bit),
		.s1_tx_valid(s1_tx_valid), .s1_tx_bit(s1_tx_bit), .s1_done(s1_done),
		.s2_tx_valid(s2_tx_valid), .s2_tx_bit(s2_tx_bit), .s2_done(s2_done),
		.m_rx_valid(m_rx_valid), .m_rx_bit(m_rx_bit),
		.m1_bus_done(m1_bus_done), .m2_bus_done(m2_bus_done), .bus_err(bus_err)
	);

endmodule

//--- hw/bus_arbiter.sv
// bus arbiter and interconnect, round-robin grant, serial steering and unmapped select handling
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_arbiter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                m1_req,
	input  logic                m2_req,
	input  bus_pkg::slave_sel_t m1_slave_sel,
	input  bus_pkg::slave_sel_t m2_slave_sel,
	output logic                m1_grant,
	output logic                m2_grant,
	input  logic                m1_tx_valid,
	input  logic                m1_tx_bit,
	input  logic                m2_tx_valid,
	input  logic                m2_tx_bit,
	output logic                s1_rx_valid,
	output logic                s2_rx_valid,
	output logic                s_rx_bit,
	input  logic                s1_tx_valid,
	input  logic                s1_tx_bit,
	input  logic                s1_done,
	input  logic                s2_tx_valid,
	input  logic                s2_tx_bit,
	input  logic                s2_done,
	output logic                m_rx_valid,
	output logic                m_rx_bit,
	output logic                m1_bus_done,
	output logic                m2_bus_done,
	output logic                bus_err
);

	import bus_pkg::*;
	import arb_pkg::*;

	localparam int         FRAME_LEN  = $bits(cmd_frame_t);
	localparam int         CNT_W      = $clog2(FRAME_LEN + 1);
	localparam slave_sel_t LAST_SLAVE = slave_sel_t'(`NUM_SLAVES - 1);

	arb_state_t       state;
	owner_t           owner;
	logic             last_m2;
	logic [CNT_W-1:0] drain_cnt;
	logic             pick_m1;
	logic             pick_m2;
	slave_sel_t       pick_sel;
	slave_sel_t       own_sel;
	logic             own_tx_valid;
	logic             own_tx_bit;
	logic             slv_done;
	logic             drain_end;
	logic             any_done;

	// round robin, m1 wins a tie unless it had the bus last
	assign pick_m1  = m1_req & (~m2_req | last_m2);
	assign pick_m2  = m2_req & ~pick_m1;
	assign pick_sel = pick_m1 ? m1_slave_sel : m2_slave_sel;

	// owner side mux
	assign own_sel      = (owner == OWN_M2) ? m2_slave_sel : m1_slave_sel;
	assign own_tx_valid = (owner == OWN_M1) ? m1_tx_valid :
	                      (owner == OWN_M2) ? m2_tx_valid : 1'b0;
	assign own_tx_bit   = (owner == OWN_M2) ? m2_tx_bit : m1_tx_bit;

	// forward path to the selected slave only
	assign s1_rx_valid = (state == ARB_XFER) && (own_sel == '0) && own_tx_valid;
	assign s2_rx_valid = (state == ARB_XFER) && (own_sel == slave_sel_t'(1)) && own_tx_valid;
	assign s_rx_bit    = own_tx_bit;

	// return path from the selected slave
	assign m_rx_valid = (state == ARB_XFER) && ((own_sel == '0) ? s1_tx_valid : s2_tx_valid);
	assign m_rx_bit   = (own_sel == '0) ? s1_tx_bit : s2_tx_bit;
	assign slv_done   = (own_sel == '0) ? s1_done : s2_done;

	// unmapped select ends one cycle after its last frame bit
	assign drain_end   = (state == ARB_DRAIN) && (drain_cnt == CNT_W'(FRAME_LEN));
	assign any_done    = ((state == ARB_XFER) && slv_done) || drain_end;
	assign m1_bus_done = any_done && (owner == OWN_M1);
	assign m2_bus_done = any_done && (owner == OWN_M2);
	assign bus_err     = drain_end;

	assign m1_grant = (owner == OWN_M1);
	assign m2_grant = (owner == OWN_M2);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= ARB_IDLE;
			owner     <= OWN_NONE;
			last_m2   <= 1'b1;
			drain_cnt <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick_m1 || pick_m2) begin
						owner   <= pick_m1 ? OWN_M1 : OWN_M2;
						last_m2 <= pick_m2;
						state   <= (pick_sel <= LAST_SLAVE) ? ARB_XFER : ARB_DRAIN;
					end
				end
				ARB_XFER: begin
					// bus freed on the slave done
					if (slv_done) begin
						owner <= OWN_NONE;
						state <= ARB_IDLE;
					end
				end
				ARB_DRAIN: begin
					if (drain_end) begin
						drain_cnt <= '0;
						owner     <= OWN_NONE;
						state     <= ARB_IDLE;
					end else if (own_tx_valid) begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				default: begin
					owner <= OWN_NONE;
					state <= ARB_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/slave_port.sv
// block ram slave port, takes a serial command frame and answers reads serially
`timescale 1ns/1ps

module slave_port (
	input  logic clk,
	input  logic rst_n,
	input  logic rx_valid,
	input  logic rx_bit,
	output logic tx_valid,
	output logic tx_bit,
	output logic done
);

	import bus_pkg::*;

	localparam int FRAME_LEN = $bits(cmd_frame_t);
	localparam int CNT_W     = $clog2(FRAME_LEN);
	localparam int DEPTH     = 2 ** $bits(addr_t);

	data_t                mem [DEPTH];
	logic [FRAME_LEN-2:0] shreg;
	logic [CNT_W-1:0]     cnt;
	cmd_frame_t           frame;
	logic                 frame_end;
	logic                 wr_pend;
	addr_t                wr_addr;
	data_t                wr_data;
	logic                 rd_last;

	// full frame seen in the cycle of its final bit
	assign frame     = cmd_frame_t'({rx_bit, shreg});
	assign frame_end = rx_valid && (cnt == CNT_W'(FRAME_LEN - 1));

	// bit counter and pending write flag
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt     <= '0;
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= frame_end & frame.write;
			if (frame_end) begin
				cnt <= '0;
			end else if (rx_valid) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// shift in, capture write, commit to ram a cycle after the frame
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			shreg <= frame[FRAME_LEN-1:1];
		end
		if (frame_end) begin
			wr_addr <= frame.addr;
			wr_data <= frame.wdata;
		end
		if (wr_pend) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read data starts the cycle after the last frame bit
	frame_serializer #(
		.payload_t(data_t)
	) i_rd_ser (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (frame_end & ~frame.write),
		.payload(mem[frame.addr]),
		.valid  (tx_valid),
		.bit_out(tx_bit),
		.last   (rd_last)
	);

	assign done = wr_pend | rd_last;

endmodule

//--- hw/master_port.sv
// bus master port that turns a command strobe into a bus request, a serial frame and a report
`timescale 1ns/1ps
`include "bus_config.svh"

module master_port (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_strobe,
	input  logic                cmd_write,
	input  bus_pkg::slave_sel_t cmd_slave,
	input  bus_pkg::addr_t      cmd_addr,
	input  bus_pkg::data_t      cmd_wdata,
	output logic                busy,
	output logic                done,
	output logic                err,
	output bus_pkg::data_t      rdata,
	output logic                req,
	output bus_pkg::slave_sel_t slave_sel,
	input  logic                grant,
	output logic                tx_valid,
	output logic                tx_bit,
	input  logic                rx_valid,
	input  logic                rx_bit,
	input  logic                bus_done,
	input  logic                bus_err
);

	import bus_pkg::*;

	cmd_frame_t          cmd_q;
	logic                grant_q;
	logic                load;
	logic                finish;
	logic [`DATA_LEN-2:0] rbyte;
	data_t               rbyte_next;

	// strobes while busy are dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			err     <= 1'b0;
			grant_q <= 1'b0;
		end else begin
			grant_q <= grant;
			done    <= finish;
			err     <= finish & bus_err;
			if (finish) begin
				busy <= 1'b0;
			end else if (cmd_strobe) begin
				busy <= 1'b1;
			end
		end
	end

	// command and select latched once per transaction
	always_ff @(posedge clk) begin
		if (cmd_strobe && !busy) begin
			cmd_q.write <= cmd_write;
			cmd_q.addr  <= cmd_addr;
			cmd_q.wdata <= cmd_wdata;
			slave_sel   <= cmd_slave;
		end
	end

	// return byte arrives lsb first so each new bit enters at the top of the reg
	assign rbyte_next = {rx_bit, rbyte};
	always_ff @(posedge clk) begin
		if (rx_valid && grant) begin
			rbyte <= rbyte_next[`DATA_LEN-1:1];
		end
		// last read bit comes together with bus_done
		if (finish) begin
			rdata <= (rx_valid && grant) ? rbyte_next : data_t'({1'b0, rbyte});
		end
	end

	assign finish = busy & bus_done;
	// request lives exactly as long as busy
	assign req    = busy;
	// frame goes out on the first cycle of grant
	assign load   = busy & grant & ~grant_q;

	frame_serializer #(
		.payload_t(cmd_frame_t)
	) i_cmd_ser (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (load),
		.payload(cmd_q),
		.valid  (tx_valid),
		.bit_out(tx_bit),
		.last   ()
	);

endmodule

//--- hw/frame_serializer.sv
// frame serializer that shifts a parallel payload out lsb first at one bit per cycle
`timescale 1ns/1ps

module frame_serializer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     load,
	input  payload_t payload,
	output logic     valid,
	output logic     bit_out,
	output logic     last
);

	// width follows whatever payload is plugged in
	localparam int WIDTH = $bits(payload_t);
	localparam int CNT_W = $clog2(WIDTH + 1);

	logic [WIDTH-1:0] shreg;
	logic [CNT_W-1:0] cnt;

	// bits still to go
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= CNT_W'(WIDTH);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// shift register, lsb leaves first
	always_ff @(posedge clk) begin
		if (load) begin
			shreg <= WIDTH'(payload);
		end else if (cnt != '0) begin
			shreg <= {1'b0, shreg[WIDTH-1:1]};
		end
	end

	assign valid   = (cnt != '0);
	assign bit_out = shreg[0];
	// final bit of the payload
	assign last    = (cnt == CNT_W'(1));

endmodule

//--- hw/arb_pkg.sv
// arbitration types for bus ownership and the arbiter FSM
package arb_pkg;

	// who holds the bus
	typedef enum logic [1:0] {
		OWN_NONE = 2'd0,
		OWN_M1   = 2'd1,
		OWN_M2   = 2'd2
	} owner_t;

	// drain state counts the frame of an unmapped select
	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_XFER  = 2'd1,
		ARB_DRAIN = 2'd2
	} arb_state_t;

endpackage

//--- hw/bus_pkg.sv
// bus transaction types shared by the masters, the slaves and the arbiter
`include "bus_config.svh"

package bus_pkg;

	typedef logic [`ADDR_LEN-1:0] addr_t;
	typedef logic [`DATA_LEN-1:0] data_t;
	typedef logic [`SLAVE_LEN-1:0] slave_sel_t;

	// serial command, sent lsb first
	// write flag leaves first, then address, then write data
	typedef struct packed {
		data_t wdata;
		addr_t addr;
		logic  write;
	} cmd_frame_t;

endpackage

//--- hw/bus_config.svh
// bus configuration macros for the widths and the number of mapped slaves
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// ram address width, 4k locations per slave
`define ADDR_LEN 12
// data byte width
`define DATA_LEN 8
// slave select width
`define SLAVE_LEN 2
// selects 0 .. NUM_SLAVES-1 have a slave behind them
`define NUM_SLAVES 2

`endif
